/* design/opl3_pkg.sv */
package opl3_pkg;
    // register file geometry
    localparam int REG_FILE_DATA_WIDTH = 8;                   // one host byte per register
    localparam int NUM_BANKS           = 2;                   // bank 0 OPL2 compatible, bank 1 OPL3
    localparam int NUM_REG_PER_BANK    = 256;
    localparam int NUM_OPERATORS       = 18;                  // per bank
    localparam int NUM_CHANNELS        = 9;                   // per bank
    localparam int BANK_WIDTH          = $clog2(NUM_BANKS);
    localparam int REG_ADDR_WIDTH      = $clog2(NUM_REG_PER_BANK);

    // decoded field widths
    localparam int REG_FNUM_WIDTH           = 10;             // frequency number
    localparam int REG_BLOCK_WIDTH          = 3;              // octave
    localparam int REG_MULT_WIDTH           = 4;
    localparam int REG_WS_WIDTH             = 3;              // wave select
    localparam int REG_ENV_WIDTH            = 4;              // ar/dr/sl/rr
    localparam int REG_TL_WIDTH             = 6;
    localparam int REG_KSL_WIDTH            = 2;
    localparam int REG_FB_WIDTH             = 3;
    localparam int REG_CONNECTION_SEL_WIDTH = 6;              // 4-op pair enables
    localparam int REG_TIMER_WIDTH          = 8;

    // timers, counted in sample_en pulses
    localparam int NUM_TIMERS        = 2;
    localparam int TIMER1_DIV        = 4;                     // about 80 us per tick
    localparam int TIMER2_DIV        = 16;                    // about 320 us per tick
    localparam int TIMER_PRESC_WIDTH = $clog2(TIMER2_DIV);    // sized for the slower timer

    // register addresses
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_TIMER1       = 8'h02;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_TIMER2       = 8'h03;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_TIMER_CTRL   = 8'h04; // bank 1 4-op select
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_NEW          = 8'h05; // bank 1 only
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_NTS          = 8'h08;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_OP_AM_MULT   = 8'h20; // + slot offset
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_OP_KSL_TL    = 8'h40;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_OP_AR_DR     = 8'h60;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_OP_SL_RR     = 8'h80;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_OP_WS        = 8'hE0;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CH_FNUM_LO   = 8'hA0; // + channel
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CH_KON_BLOCK = 8'hB0;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CH_FB_CNT    = 8'hC0;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_RHYTHM       = 8'hBD;

    typedef logic [REG_FILE_DATA_WIDTH-1:0] reg_array_t [NUM_BANKS][NUM_REG_PER_BANK];

    // register 0x04 of bank 0 is read as timer control unless irq_rst is set
    typedef union packed {
        struct packed {
            logic       irq_rst;
            logic       mt1;                                  // mask timer 1 flag
            logic       mt2;                                  // mask timer 2 flag
            logic [2:0] unused;
            logic       st2;                                  // start timer 2
            logic       st1;                                  // start timer 1
        } ctrl;
        struct packed {
            logic       irq_rst;                              // clears both flags
            logic [6:0] ignored;
        } rst;
    } timer_ctrl_u;
endpackage

/* design/opl3_host_decode.sv */
module opl3_host_decode (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        wr,        // one-cycle write strobe
    input  logic [1:0]                                  addr,      // [0] data/addr, [1] bank
    input  logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0]    din,
    output opl3_pkg::reg_array_t                        opl3_reg,
    output logic                                        irq_rst
);
    import opl3_pkg::*;

    logic                      addr_wr;      // address phase
    logic                      data_wr;      // data phase
    logic [BANK_WIDTH-1:0]     bank;         // latched bank select
    logic [REG_ADDR_WIDTH-1:0] reg_addr;     // latched register address
    logic                      is_ctrl_reg;  // latch points at bank 0 reg 04
    logic                      rst_req;      // data write is a flag reset
    timer_ctrl_u               wr_view;      // incoming byte seen as reg 04

    assign addr_wr = wr && !addr[0];
    assign data_wr = wr && addr[0];
    assign wr_view = din;

    assign is_ctrl_reg = (bank == '0) && (reg_addr == ADDR_TIMER_CTRL);
    assign rst_req     = data_wr && is_ctrl_reg && wr_view.rst.irq_rst;

    // address latch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank     <= '0;
            reg_addr <= '0;
        end else if (addr_wr) begin
            bank     <= addr[1];   // bank chosen by the address port used
            reg_addr <= din;
        end
    end

    // register array write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opl3_reg <= '{default: '0};
        end else if (data_wr && !rst_req) begin
            opl3_reg[bank][reg_addr] <= din;   // visible one cycle after strobe
        end
    end

    // flag reset pulse
    // the byte with irq_rst set is not stored, so st/mt keep their settings
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_rst <= 1'b0;
        end else begin
            irq_rst <= rst_req && !irq_rst;   // single cycle even on back-to-back writes
        end
    end
endmodule

/* design/opl3_timers.sv */
module opl3_timers (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 sample_en,   // one pulse per output sample
    input  opl3_pkg::reg_array_t opl3_reg,
    input  logic                 irq_rst,     // clears ft1/ft2
    output logic                 ft1,         // timer 1 overflow flag
    output logic                 ft2,         // timer 2 overflow flag
    output logic                 irq
);
    import opl3_pkg::*;

    timer_ctrl_u                    ctrl;                 // bank 0 reg 04
    logic [REG_TIMER_WIDTH-1:0]     preload [NUM_TIMERS]; // regs 02/03
    logic                           start   [NUM_TIMERS];
    logic                           mask    [NUM_TIMERS];
    logic [TIMER_PRESC_WIDTH-1:0]   presc   [NUM_TIMERS]; // sample_en divider
    logic [REG_TIMER_WIDTH-1:0]     tmr_cnt [NUM_TIMERS]; // up counter
    logic                           tick    [NUM_TIMERS]; // counter step
    logic                           ovf     [NUM_TIMERS]; // step from 255
    logic                           flag    [NUM_TIMERS];

    assign ctrl = opl3_reg[0][ADDR_TIMER_CTRL];

    assign preload[0] = opl3_reg[0][ADDR_TIMER1];
    assign preload[1] = opl3_reg[0][ADDR_TIMER2];
    assign start[0]   = ctrl.ctrl.st1;
    assign start[1]   = ctrl.ctrl.st2;
    assign mask[0]    = ctrl.ctrl.mt1;
    assign mask[1]    = ctrl.ctrl.mt2;

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        localparam int DIV = (i == 0) ? TIMER1_DIV : TIMER2_DIV;

        assign tick[i] = start[i] && sample_en
                         && (presc[i] == TIMER_PRESC_WIDTH'(DIV - 1));
        assign ovf[i]  = tick[i] && (tmr_cnt[i] == '1);

        // prescaler restarts whenever the timer is stopped
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                presc[i] <= '0;
            end else if (!start[i]) begin
                presc[i] <= '0;
            end else if (sample_en) begin
                if (presc[i] == TIMER_PRESC_WIDTH'(DIV - 1))
                    presc[i] <= '0;
                else
                    presc[i] <= presc[i] + 1'b1;
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                tmr_cnt[i] <= '0;
            end else if (!start[i]) begin
                tmr_cnt[i] <= preload[i];           // stopped timer tracks preload
            end else if (ovf[i]) begin
                tmr_cnt[i] <= preload[i];           // reload on overflow
            end else if (tick[i]) begin
                tmr_cnt[i] <= tmr_cnt[i] + 1'b1;
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                flag[i] <= 1'b0;
            end else if (irq_rst) begin
                flag[i] <= 1'b0;                    // reset beats a same-cycle set
            end else if (ovf[i] && !mask[i]) begin
                flag[i] <= 1'b1;                    // masked timer still reloads
            end
        end
    end

    assign ft1 = flag[0];
    assign ft2 = flag[1];
    assign irq = ft1 || ft2;   // level, held until irq_rst
endmodule

/* design/opl3_reg_fields.sv */
module opl3_reg_fields (
    input  opl3_pkg::reg_array_t opl3_reg,
    input  logic                 ft1,
    input  logic                 ft2,
    input  logic                 irq,
    // globals
    output logic [opl3_pkg::REG_CONNECTION_SEL_WIDTH-1:0] connection_sel,
    output logic is_new,                                     // OPL3 mode enable
    output logic nts,                                        // keyboard split select
    output logic dam,                                        // tremolo depth
    output logic dvb,                                        // vibrato depth
    output logic ryt,                                        // rhythm mode
    output logic bd,
    output logic sd,
    output logic tom,
    output logic tc,
    output logic hh,
    // per operator
    output logic am  [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic vib [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic egt [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS], // sustain envelope
    output logic ksr [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_MULT_WIDTH-1:0] mult [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_KSL_WIDTH-1:0]  ksl  [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_TL_WIDTH-1:0]   tl   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_ENV_WIDTH-1:0]  ar   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_ENV_WIDTH-1:0]  dr   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_ENV_WIDTH-1:0]  sl   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_ENV_WIDTH-1:0]  rr   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_WS_WIDTH-1:0]   ws   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    // per channel
    output logic [opl3_pkg::REG_FNUM_WIDTH-1:0]  fnum  [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic [opl3_pkg::REG_BLOCK_WIDTH-1:0] block [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic kon [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic cha [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS], // output routing
    output logic chb [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic chc [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic chd [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic [opl3_pkg::REG_FB_WIDTH-1:0] fb [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic cnt [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS], // FM/AM connection
    output logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0] status
);
    import opl3_pkg::*;

    // bank-specific globals
    always_comb begin
        connection_sel = opl3_reg[1][ADDR_TIMER_CTRL][REG_CONNECTION_SEL_WIDTH-1:0];
        is_new         = opl3_reg[1][ADDR_NEW][0];
        nts            = opl3_reg[0][ADDR_NTS][6];

        dam = opl3_reg[0][ADDR_RHYTHM][7];
        dvb = opl3_reg[0][ADDR_RHYTHM][6];
        ryt = opl3_reg[0][ADDR_RHYTHM][5];
        bd  = opl3_reg[0][ADDR_RHYTHM][4];
        sd  = opl3_reg[0][ADDR_RHYTHM][3];
        tom = opl3_reg[0][ADDR_RHYTHM][2];
        tc  = opl3_reg[0][ADDR_RHYTHM][1];
        hh  = opl3_reg[0][ADDR_RHYTHM][0];
    end

    for (genvar bank = 0; bank < NUM_BANKS; bank++) begin : g_bank
        // slots 0-5, 8-13, 16-21 hold operators 0-17
        for (genvar op = 0; op < NUM_OPERATORS; op++) begin : g_op
            localparam int SLOT = op + 2 * (op / 6);

            always_comb begin
                am[bank][op]   = opl3_reg[bank][ADDR_OP_AM_MULT + SLOT][7];
                vib[bank][op]  = opl3_reg[bank][ADDR_OP_AM_MULT + SLOT][6];
                egt[bank][op]  = opl3_reg[bank][ADDR_OP_AM_MULT + SLOT][5];
                ksr[bank][op]  = opl3_reg[bank][ADDR_OP_AM_MULT + SLOT][4];
                mult[bank][op] = opl3_reg[bank][ADDR_OP_AM_MULT + SLOT][3:0];

                ksl[bank][op] = opl3_reg[bank][ADDR_OP_KSL_TL + SLOT][7:6];
                tl[bank][op]  = opl3_reg[bank][ADDR_OP_KSL_TL + SLOT][5:0];   // attenuation

                ar[bank][op] = opl3_reg[bank][ADDR_OP_AR_DR + SLOT][7:4];
                dr[bank][op] = opl3_reg[bank][ADDR_OP_AR_DR + SLOT][3:0];

                sl[bank][op] = opl3_reg[bank][ADDR_OP_SL_RR + SLOT][7:4];
                rr[bank][op] = opl3_reg[bank][ADDR_OP_SL_RR + SLOT][3:0];

                ws[bank][op] = opl3_reg[bank][ADDR_OP_WS + SLOT][2:0];   // 8 waveforms
            end
        end

        for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_ch
            always_comb begin
                fnum[bank][ch][7:0] = opl3_reg[bank][ADDR_CH_FNUM_LO + ch];   // low byte

                kon[bank][ch]       = opl3_reg[bank][ADDR_CH_KON_BLOCK + ch][5];
                block[bank][ch]     = opl3_reg[bank][ADDR_CH_KON_BLOCK + ch][4:2];
                fnum[bank][ch][9:8] = opl3_reg[bank][ADDR_CH_KON_BLOCK + ch][1:0];

                chd[bank][ch] = opl3_reg[bank][ADDR_CH_FB_CNT + ch][7];
                chc[bank][ch] = opl3_reg[bank][ADDR_CH_FB_CNT + ch][6];
                chb[bank][ch] = opl3_reg[bank][ADDR_CH_FB_CNT + ch][5];
                cha[bank][ch] = opl3_reg[bank][ADDR_CH_FB_CNT + ch][4];
                fb[bank][ch]  = opl3_reg[bank][ADDR_CH_FB_CNT + ch][3:1];
                cnt[bank][ch] = opl3_reg[bank][ADDR_CH_FB_CNT + ch][0];
            end
        end
    end

    // only readable byte on the host port
    always_comb begin
        status    = '0;   // low bits read as zero
        status[7] = irq;
        status[6] = ft1;
        status[5] = ft2;
    end
endmodule

/* design/opl3_regs_top.sv */
module opl3_regs_top (
    input  logic clk,
    input  logic arst_n,
    input  logic wr,
    input  logic [1:0] addr,
    input  logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0] din,
    input  logic sample_en,
    output logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0] dout,   // status byte
    output logic irq_n,                                      // active-low interrupt pin
    output logic [opl3_pkg::REG_CONNECTION_SEL_WIDTH-1:0] connection_sel,
    output logic is_new,
    output logic nts,
    output logic dam,
    output logic dvb,
    output logic ryt,
    output logic bd,
    output logic sd,
    output logic tom,
    output logic tc,
    output logic hh,
    output logic am  [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic vib [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic egt [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic ksr [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_MULT_WIDTH-1:0] mult [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_KSL_WIDTH-1:0]  ksl  [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_TL_WIDTH-1:0]   tl   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_ENV_WIDTH-1:0]  ar   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_ENV_WIDTH-1:0]  dr   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_ENV_WIDTH-1:0]  sl   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_ENV_WIDTH-1:0]  rr   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_WS_WIDTH-1:0]   ws   [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_OPERATORS],
    output logic [opl3_pkg::REG_FNUM_WIDTH-1:0]  fnum  [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic [opl3_pkg::REG_BLOCK_WIDTH-1:0] block [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic kon [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic cha [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic chb [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic chc [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic chd [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic [opl3_pkg::REG_FB_WIDTH-1:0] fb [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS],
    output logic cnt [opl3_pkg::NUM_BANKS][opl3_pkg::NUM_CHANNELS]
);
    import opl3_pkg::*;

    reg_array_t opl3_reg;   // both banks, decoder to timers and fields
    logic       irq_rst;
    logic       ft1;
    logic       ft2;
    logic       irq;

    opl3_host_decode opl3_host_decode_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (wr),
        .addr     (addr),
        .din      (din),
        .opl3_reg (opl3_reg),
        .irq_rst  (irq_rst)
    );

    opl3_timers opl3_timers_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sample_en (sample_en),
        .opl3_reg  (opl3_reg),
        .irq_rst   (irq_rst),
        .ft1       (ft1),
        .ft2       (ft2),
        .irq       (irq)
    );

    // field names match the top ports one to one
    opl3_reg_fields opl3_reg_fields_i (
        .*,
        .status (dout)
    );

    assign irq_n = !irq;   // pin is active low
endmodule

/* verification/opl3_regs_assert.sv */
module opl3_regs_assert (
    input logic clk,
    input logic arst_n,
    input logic irq_rst,
    input logic ft1,
    input logic ft2,
    input logic irq
);
    timeunit 1ns;
    timeprecision 100ps;

    // reset pulse from the decoder is one cycle wide
    a_irq_rst_single : assert property (
        @(posedge clk) disable iff (!arst_n)
        irq_rst |=> !irq_rst
    ) else $error("irq_rst held high for two cycles");

    // interrupt level stays up until irq_rst
    a_irq_held : assert property (
        @(posedge clk) disable iff (!arst_n)
        ((ft1 || ft2) && !irq_rst) |=> irq
    ) else $error("irq dropped while a flag was set and no irq_rst came");

    // flags cleared right after the pulse
    a_flags_cleared : assert property (
        @(posedge clk) disable iff (!arst_n)
        irq_rst |=> (!ft1 && !ft2)
    ) else $error("flags still set in the cycle after irq_rst");
endmodule

// irq_rst enters the timers straight from the host decoder
bind opl3_timers opl3_regs_assert opl3_regs_assert_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .irq_rst (irq_rst),
    .ft1     (ft1),
    .ft2     (ft2),
    .irq     (irq)
);

/* verification/opl3_regs_tb.sv */
module opl3_regs_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import opl3_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int SAMPLE_SPACING = 3;                            // sample_en every 3rd cycle
    localparam int MAX_WAIT_CYC   = 256 * TIMER2_DIV * SAMPLE_SPACING; // full timer 2 run
    localparam int IDLE_CYC       = 4 * 2 * TIMER1_DIV * SAMPLE_SPACING; // 4 periods at FE
    localparam int TABLE_LEN      = 27;
    localparam int K_OPS = 0, K_CHS = 1, K_WR = 2, K_WAIT = 3, K_IDLE = 4, K_STAT = 5;

    typedef struct {
        int   kind;     // operation and expected output kind
        int   bank;
        int   addr;     // base address for sweeps
        int   data;     // byte, flag mask or expected status
        bit   rnd;      // data taken from the LFSR
    } entry_t;

    logic clk, arst_n, wr, sample_en;
    logic [1:0] addr;
    logic [7:0] din, dout;
    logic irq_n;
    logic [REG_CONNECTION_SEL_WIDTH-1:0] connection_sel;
    logic is_new, nts, dam, dvb, ryt, bd, sd, tom, tc, hh;
    logic am [NUM_BANKS][NUM_OPERATORS];
    logic vib [NUM_BANKS][NUM_OPERATORS];
    logic egt [NUM_BANKS][NUM_OPERATORS];
    logic ksr [NUM_BANKS][NUM_OPERATORS];
    logic [REG_MULT_WIDTH-1:0] mult [NUM_BANKS][NUM_OPERATORS];
    logic [REG_KSL_WIDTH-1:0]  ksl  [NUM_BANKS][NUM_OPERATORS];
    logic [REG_TL_WIDTH-1:0]   tl   [NUM_BANKS][NUM_OPERATORS];
    logic [REG_ENV_WIDTH-1:0]  ar   [NUM_BANKS][NUM_OPERATORS];
    logic [REG_ENV_WIDTH-1:0]  dr   [NUM_BANKS][NUM_OPERATORS];
    logic [REG_ENV_WIDTH-1:0]  sl   [NUM_BANKS][NUM_OPERATORS];
    logic [REG_ENV_WIDTH-1:0]  rr   [NUM_BANKS][NUM_OPERATORS];
    logic [REG_WS_WIDTH-1:0]   ws   [NUM_BANKS][NUM_OPERATORS];
    logic [REG_FNUM_WIDTH-1:0]  fnum  [NUM_BANKS][NUM_CHANNELS];
    logic [REG_BLOCK_WIDTH-1:0] block [NUM_BANKS][NUM_CHANNELS];
    logic kon [NUM_BANKS][NUM_CHANNELS];
    logic cha [NUM_BANKS][NUM_CHANNELS];
    logic chb [NUM_BANKS][NUM_CHANNELS];
    logic chc [NUM_BANKS][NUM_CHANNELS];
    logic chd [NUM_BANKS][NUM_CHANNELS];
    logic [REG_FB_WIDTH-1:0] fb [NUM_BANKS][NUM_CHANNELS];
    logic cnt [NUM_BANKS][NUM_CHANNELS];

    logic [7:0]  model [NUM_BANKS][NUM_REG_PER_BANK];   // expected register contents
    logic [15:0] lfsr_state = 16'd53413;
    int          sample_cnt;
    int          slot_map [NUM_OPERATORS] = '{0, 1, 2, 3, 4, 5, 8, 9, 10, 11, 12, 13,
                                              16, 17, 18, 19, 20, 21};

    entry_t stim [TABLE_LEN] = '{
        '{K_OPS, 0, 'h20, 0, 1}, '{K_OPS, 0, 'h40, 0, 1}, '{K_OPS, 0, 'h60, 0, 1},
        '{K_OPS, 0, 'h80, 0, 1}, '{K_OPS, 0, 'hE0, 0, 1},
        '{K_CHS, 0, 'hA0, 0, 1}, '{K_CHS, 0, 'hB0, 0, 1}, '{K_CHS, 0, 'hC0, 0, 1},
        '{K_WR, 0, 'hBD, 0, 1}, '{K_WR, 0, 'h08, 0, 1},
        '{K_WR, 0, 'h02, 'hFE, 0}, '{K_WR, 0, 'h03, 'hFF, 0},   // preloads, timers stopped
        '{K_WR, 1, 'h04, 'h3F, 0}, '{K_WR, 1, 'h05, 'h01, 0},   // bank 1 reg 04 is no timer ctrl
        '{K_IDLE, 0, 0, 'hE0, 0}, '{K_STAT, 0, 0, 'h00, 0},
        '{K_WR, 0, 'h04, 'h03, 0}, '{K_WAIT, 0, 0, 'h60, 0},     // st1 and st2
        '{K_WR, 0, 'h04, 'h80, 0}, '{K_STAT, 0, 0, 'h00, 0},     // flag reset
        '{K_WAIT, 0, 0, 'h60, 0},
        '{K_WR, 0, 'h04, 'h43, 0}, '{K_STAT, 0, 0, 'hE0, 0},     // mt1 on, flags kept
        '{K_WR, 0, 'h04, 'h80, 0},                               // then clear
        '{K_STAT, 0, 0, 'h00, 0}, '{K_IDLE, 0, 0, 'h40, 0},
        '{K_WAIT, 0, 0, 'h20, 0}                                 // ft2 still works
    };

    opl3_regs_top opl3_regs_top_i (.*);

    always #(CLK_PERIOD / 2) clk = !clk;

    // sample pulse, driven off the clock edge like the other inputs
    always @(posedge clk) begin
        #1;
        if (!arst_n) begin
            sample_cnt = 0;
            sample_en  = 1'b0;
        end else begin
            sample_en  = (sample_cnt == SAMPLE_SPACING - 1);
            sample_cnt = (sample_cnt == SAMPLE_SPACING - 1) ? 0 : sample_cnt + 1;
        end
    end

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 16'hB400;   // galois taps 16,14,13,11
        return out;
    endfunction

    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++)
            b[i] = lfsr_bit();   // one step per bit
        return b;
    endfunction

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_status(input logic [7:0] exp);
        check_val("dout", dout, exp);
        check_val("irq_n", irq_n, !exp[7]);
    endtask

    // every decoded field against the model array
    task automatic check_fields();
        logic [7:0] r;
        check_val("connection_sel", connection_sel, model[1]['h04][5:0]);
        check_val("is_new", is_new, model[1]['h05][0]);
        check_val("nts", nts, model[0]['h08][6]);
        r = model[0]['hBD];
        check_val("rhythm", {dam, dvb, ryt, bd, sd, tom, tc, hh}, r);
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int op = 0; op < NUM_OPERATORS; op++) begin
                r = model[b]['h20 + slot_map[op]];
                check_val($sformatf("am_vib_egt_ksr[%0d][%0d]", b, op),
                          {am[b][op], vib[b][op], egt[b][op], ksr[b][op]}, r[7:4]);
                check_val($sformatf("mult[%0d][%0d]", b, op), mult[b][op], r[3:0]);
                r = model[b]['h40 + slot_map[op]];
                check_val($sformatf("ksl[%0d][%0d]", b, op), ksl[b][op], r[7:6]);
                check_val($sformatf("tl[%0d][%0d]", b, op), tl[b][op], r[5:0]);
                r = model[b]['h60 + slot_map[op]];
                check_val($sformatf("ar_dr[%0d][%0d]", b, op), {ar[b][op], dr[b][op]}, r);
                r = model[b]['h80 + slot_map[op]];
                check_val($sformatf("sl_rr[%0d][%0d]", b, op), {sl[b][op], rr[b][op]}, r);
                r = model[b]['hE0 + slot_map[op]];
                check_val($sformatf("ws[%0d][%0d]", b, op), ws[b][op], r[2:0]);
            end
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                r = model[b]['hB0 + ch];
                check_val($sformatf("fnum[%0d][%0d]", b, ch), fnum[b][ch],
                          {r[1:0], model[b]['hA0 + ch]});
                check_val($sformatf("kon_block[%0d][%0d]", b, ch),
                          {kon[b][ch], block[b][ch]}, r[5:2]);
                r = model[b]['hC0 + ch];
                check_val($sformatf("chan_c0[%0d][%0d]", b, ch),
                          {chd[b][ch], chc[b][ch], chb[b][ch], cha[b][ch], fb[b][ch],
                           cnt[b][ch]}, r);
            end
        end
    endtask

    // address phase, data phase, then one cycle for the flag reset to land
    task automatic host_write(input int bank, input int a, input logic [7:0] d);
        @(posedge clk);
        #1;
        wr   = 1'b1;
        addr = {bank[0], 1'b0};
        din  = a[7:0];
        @(posedge clk);
        #1;
        addr = {bank[0], 1'b1};
        din  = d;
        @(posedge clk);
        #1;
        wr = 1'b0;
        if (!(bank == 0 && a == 'h04 && d[7]))
            model[bank][a] = d;   // flag reset byte is not stored
        check_fields();           // fields follow one cycle after the data strobe
        @(posedge clk);
        #1;
    endtask

    task automatic wait_flags(input logic [7:0] mask);
        int n;
        n = 0;
        while ((dout & mask) != mask) begin
            @(posedge clk);
            #1;
            n++;
            if (n > MAX_WAIT_CYC) begin
                $display("timer flags never rose within the wait limit");
                fail_run();
            end
        end
        check_status(mask | 8'h80);
    endtask

    task automatic run_idle(input logic [7:0] mask);
        repeat (IDLE_CYC) begin
            @(posedge clk);
            #1;
            check_val("dout_masked", dout & mask, 8'h00);
        end
    endtask

    initial begin
        #(TABLE_LEN * MAX_WAIT_CYC * CLK_PERIOD);
        $display("watchdog timeout, the test did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        din       = '0;
        sample_en = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++)
            for (int a = 0; a < NUM_REG_PER_BANK; a++)
                model[b][a] = 8'h00;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_fields();
        check_status(8'h00);

        foreach (stim[i]) begin
            case (stim[i].kind)
                K_OPS: begin
                    for (int b = 0; b < NUM_BANKS; b++)
                        for (int op = 0; op < NUM_OPERATORS; op++)
                            host_write(b, stim[i].addr + slot_map[op], lfsr_byte());
                end
                K_CHS: begin
                    for (int b = 0; b < NUM_BANKS; b++)
                        for (int ch = 0; ch < NUM_CHANNELS; ch++)
                            host_write(b, stim[i].addr + ch, lfsr_byte());
                end
                K_WR: begin
                    host_write(stim[i].bank, stim[i].addr,
                               stim[i].rnd ? lfsr_byte() : stim[i].data[7:0]);
                end
                K_WAIT:  wait_flags(stim[i].data[7:0]);
                K_IDLE:  run_idle(stim[i].data[7:0]);
                default: check_status(stim[i].data[7:0]);
            endcase
        end

        $display("TEST PASSED");
        $finish;
    end
endmodule

/* src.f */
design/opl3_pkg.sv
design/opl3_host_decode.sv
design/opl3_timers.sv
design/opl3_reg_fields.sv
design/opl3_regs_top.sv
verification/opl3_regs_assert.sv
verification/opl3_regs_tb.sv

/* Bender.yml */
package:
  name: opl3_regs

sources:
  - design/opl3_pkg.sv
  - design/opl3_host_decode.sv
  - design/opl3_timers.sv
  - design/opl3_reg_fields.sv
  - design/opl3_regs_top.sv
  - target: simulation
    files:
      - verification/opl3_regs_assert.sv
      - verification/opl3_regs_tb.sv
